// File: logic/csr_pkg.sv
// -------------------------------------------------------------------------
// Shared CSR definitions: address type, operation encoding, CSR address
// map, immediate width and the warp id width helper
// -------------------------------------------------------------------------

package csr_pkg;

    typedef logic [11:0] csr_addr_t;

    // Matches the low two bits of the RISC-V funct3 field
    typedef enum logic [1:0] {
        op_csrrw = 2'd1,
        op_csrrs = 2'd2,
        op_csrrc = 2'd3
    } csr_op_e;

    // Machine scratch, one per warp
    localparam csr_addr_t csr_mscratch = 12'h340;

    // Low words of the 64-bit counters
    localparam csr_addr_t csr_mcycle = 12'hB00;
    localparam csr_addr_t csr_minstret = 12'hB02;

    // GPU-specific identification registers
    localparam csr_addr_t csr_thread_id = 12'hCC0;
    localparam csr_addr_t csr_warp_id = 12'hCC1;
    localparam csr_addr_t csr_mhartid = 12'hF14;

    localparam int csr_zimm_width = 5;

    // Warp id field is at least one bit wide, even with a single warp
    function automatic int csr_wid_bits(int num_warps);
        int bits;
        bits = (num_warps > 1) ? $clog2(num_warps) : 1;
        return bits;
    endfunction

endpackage

// File: logic/csr_req_if.sv
// -------------------------------------------------------------------------
// Request interface from the execute stage into the CSR unit
// -------------------------------------------------------------------------

`timescale 1ns/1ns

interface csr_req_if #(
    parameter int num_lanes = 4,
    parameter int num_warps = 4
);

    localparam int wid_bits = csr_pkg::csr_wid_bits(num_warps);

    logic valid;
    logic ready;
    logic [wid_bits-1:0] wid;
    logic [num_lanes-1:0] tmask;
    logic [31:0] pc;
    logic [4:0] rd;
    logic wb;
    logic sop;
    logic eop;
    csr_pkg::csr_op_e op;
    csr_pkg::csr_addr_t addr;
    logic [csr_pkg::csr_zimm_width-1:0] zimm;
    logic use_imm;
    logic [num_lanes-1:0][31:0] rs1;

    modport src (
        output valid, wid, tmask, pc, rd, wb, sop, eop, op, addr, zimm, use_imm, rs1,
        input  ready
    );

    modport dst (
        input  valid, wid, tmask, pc, rd, wb, sop, eop, op, addr, zimm, use_imm, rs1,
        output ready
    );

endinterface

// File: logic/csr_commit_if.sv
// -------------------------------------------------------------------------
// Commit interface carrying CSR results towards write-back
// -------------------------------------------------------------------------

`timescale 1ns/1ns

interface csr_commit_if #(
    parameter int num_lanes = 4,
    parameter int num_warps = 4
);

    localparam int wid_bits = csr_pkg::csr_wid_bits(num_warps);

    logic valid;
    logic ready;
    logic [wid_bits-1:0] wid;
    logic [num_lanes-1:0] tmask;
    logic [31:0] pc;
    logic [4:0] rd;
    logic wb;
    logic sop;
    logic eop;
    logic [num_lanes-1:0][31:0] data;

    modport mst (output valid, wid, tmask, pc, rd, wb, sop, eop, data, input ready);

    modport slv (input valid, wid, tmask, pc, rd, wb, sop, eop, data, output ready);

endinterface

// File: logic/csr_data.sv
// -------------------------------------------------------------------------
// CSR storage: per-warp scratch registers, cycle and retired-instruction
// counters, and the read multiplexer for stored registers
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_data #(
    parameter int num_warps = 4
) (
    input  logic clk,
    input  logic rst_n,

    input  logic retire,

    input  logic [csr_pkg::csr_wid_bits(num_warps)-1:0] read_wid,
    input  csr_pkg::csr_addr_t read_addr,
    output logic [31:0] read_data,

    input  logic write_enable,
    input  logic [csr_pkg::csr_wid_bits(num_warps)-1:0] write_wid,
    input  csr_pkg::csr_addr_t write_addr,
    input  logic [31:0] write_data
);

    logic [31:0] scratch [num_warps];
    logic [63:0] mcycle;
    logic [63:0] minstret;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (retire) begin
                minstret <= minstret + 64'd1;
            end
        end
    end

    // Only mscratch is writable, other addresses drop the write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < num_warps; w++) begin
                scratch[w] <= '0;
            end
        end else if (write_enable && (write_addr == csr_pkg::csr_mscratch)) begin
            scratch[write_wid] <= write_data;
        end
    end

    always_comb begin
        case (read_addr)
            csr_pkg::csr_mscratch: begin
                read_data = scratch[read_wid];
            end
            csr_pkg::csr_mcycle: begin
                read_data = mcycle[31:0];
            end
            csr_pkg::csr_minstret: begin
                read_data = minstret[31:0];
            end
            csr_pkg::csr_warp_id: begin
                read_data = 32'(read_wid);
            end
            default: begin
                read_data = '0;
            end
        endcase
    end

endmodule

// File: logic/csr_rsp_buffer.sv
// -------------------------------------------------------------------------
// Two-entry elastic buffer with registered output and skid register
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_rsp_buffer #(
    parameter int width = 32
) (
    input  logic clk,
    input  logic rst_n,

    input  logic valid_in,
    output logic ready_in,
    input  logic [width-1:0] data_in,

    output logic valid_out,
    input  logic ready_out,
    output logic [width-1:0] data_out
);

    logic [1:0] count;
    logic [width-1:0] head_q;
    logic [width-1:0] skid_q;
    logic push;
    logic pop;

    assign ready_in = (count != 2'd2);
    assign valid_out = (count != 2'd0);
    assign data_out = head_q;

    assign push = valid_in && ready_in;
    assign pop = valid_out && ready_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    // Head is loaded directly when empty or draining, otherwise from the skid
    always_ff @(posedge clk) begin
        if (push && ((count == 2'd0) || ((count == 2'd1) && pop))) begin
            head_q <= data_in;
        end else if (pop && (count == 2'd2)) begin
            head_q <= skid_q;
        end
        if (push && (count == 2'd1) && !pop) begin
            skid_q <= data_in;
        end
    end

endmodule

// File: logic/csr_unit.sv
// -------------------------------------------------------------------------
// CSR unit: warp-idle gating, per-lane id generation, read selection,
// write value computation, scheduler unlock and response buffering
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_unit #(
    parameter int num_lanes = 4,
    parameter int num_warps = 4,
    parameter int core_id = 0
) (
    input  logic clk,
    input  logic rst_n,

    csr_req_if.dst req,
    csr_commit_if.mst cmt,

    input  logic [num_warps-1:0] warp_idle,
    input  logic retire,

    output logic unlock,
    output logic [csr_pkg::csr_wid_bits(num_warps)-1:0] unlock_wid
);

    localparam int wid_bits = csr_pkg::csr_wid_bits(num_warps);
    localparam int lane_bits = $clog2(num_lanes);
    localparam int warp_bits = $clog2(num_warps);
    localparam int rec_width = wid_bits + num_lanes + 32 + 5 + 3 + num_lanes * 32;

    logic idle;
    logic buf_ready;
    logic accept;
    logic [31:0] stored_value;
    logic [31:0] src_value;
    logic [31:0] write_value;
    logic write_en;
    logic [num_lanes-1:0][31:0] tid;
    logic [num_lanes-1:0][31:0] gid;
    logic [num_lanes-1:0][31:0] read_lanes;
    logic [rec_width-1:0] rec_in;
    logic [rec_width-1:0] rec_out;

    // Hold the request until the warp has drained its pipeline
    assign idle = warp_idle[req.wid];
    assign req.ready = buf_ready && idle;
    assign accept = req.valid && req.ready;

    csr_data #(
        .num_warps (num_warps)
    ) data_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .retire       (retire),
        .read_wid     (req.wid),
        .read_addr    (req.addr),
        .read_data    (stored_value),
        .write_enable (accept && write_en),
        .write_wid    (req.wid),
        .write_addr   (req.addr),
        .write_data   (write_value)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assign tid[i] = 32'(i);
        assign gid[i] = (32'(core_id) << (warp_bits + lane_bits))
                      + (32'(req.wid) << lane_bits)
                      + 32'(i);
    end

    always_comb begin
        case (req.addr)
            csr_pkg::csr_thread_id: read_lanes = tid;
            csr_pkg::csr_mhartid: read_lanes = gid;
            default: read_lanes = {num_lanes{stored_value}};
        endcase
    end

    assign src_value = req.use_imm ? 32'(req.zimm) : req.rs1[0];

    // Set and clear with a zero source behave as a plain read
    assign write_en = (req.op == csr_pkg::op_csrrw) || (|src_value);

    always_comb begin
        case (req.op)
            csr_pkg::op_csrrs: write_value = stored_value | src_value;
            csr_pkg::op_csrrc: write_value = stored_value & ~src_value;
            default: write_value = src_value;
        endcase
    end

    assign unlock = rst_n && accept && req.eop;
    assign unlock_wid = req.wid;

    assign rec_in = {req.wid, req.tmask, req.pc, req.rd, req.wb, req.sop, req.eop, read_lanes};

    csr_rsp_buffer #(
        .width (rec_width)
    ) rsp_buf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (req.valid && idle),
        .ready_in  (buf_ready),
        .data_in   (rec_in),
        .valid_out (cmt.valid),
        .ready_out (cmt.ready),
        .data_out  (rec_out)
    );

    assign {cmt.wid, cmt.tmask, cmt.pc, cmt.rd, cmt.wb, cmt.sop, cmt.eop, cmt.data} = rec_out;

endmodule

// File: logic/csr_core.sv
// -------------------------------------------------------------------------
// CSR core top level: plain request, scheduler and commit ports
// -------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_core #(
    parameter int num_lanes = 4,
    parameter int num_warps = 4,
    parameter int core_id = 0
) (
    input  logic clk,
    input  logic rst_n,

    input  logic req_valid,
    output logic req_ready,
    input  logic [csr_pkg::csr_wid_bits(num_warps)-1:0] req_wid,
    input  logic [num_lanes-1:0] req_tmask,
    input  logic [31:0] req_pc,
    input  logic [4:0] req_rd,
    input  logic req_wb,
    input  logic req_sop,
    input  logic req_eop,
    input  csr_pkg::csr_op_e req_op,
    input  csr_pkg::csr_addr_t req_addr,
    input  logic [csr_pkg::csr_zimm_width-1:0] req_zimm,
    input  logic req_use_imm,
    input  logic [num_lanes-1:0][31:0] req_rs1,

    input  logic [num_warps-1:0] warp_idle,
    input  logic retire,
    output logic unlock,
    output logic [csr_pkg::csr_wid_bits(num_warps)-1:0] unlock_wid,

    output logic cmt_valid,
    input  logic cmt_ready,
    output logic [csr_pkg::csr_wid_bits(num_warps)-1:0] cmt_wid,
    output logic [num_lanes-1:0] cmt_tmask,
    output logic [31:0] cmt_pc,
    output logic [4:0] cmt_rd,
    output logic cmt_wb,
    output logic cmt_sop,
    output logic cmt_eop,
    output logic [num_lanes-1:0][31:0] cmt_data
);

    csr_req_if #(.num_lanes(num_lanes), .num_warps(num_warps)) req_if ();
    csr_commit_if #(.num_lanes(num_lanes), .num_warps(num_warps)) cmt_if ();

    assign req_if.valid = req_valid;
    assign req_if.wid = req_wid;
    assign req_if.tmask = req_tmask;
    assign req_if.pc = req_pc;
    assign req_if.rd = req_rd;
    assign req_if.wb = req_wb;
    assign req_if.sop = req_sop;
    assign req_if.eop = req_eop;
    assign req_if.op = req_op;
    assign req_if.addr = req_addr;
    assign req_if.zimm = req_zimm;
    assign req_if.use_imm = req_use_imm;
    assign req_if.rs1 = req_rs1;
    assign req_ready = req_if.ready;

    csr_unit #(
        .num_lanes (num_lanes),
        .num_warps (num_warps),
        .core_id   (core_id)
    ) unit_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req_if),
        .cmt        (cmt_if),
        .warp_idle  (warp_idle),
        .retire     (retire),
        .unlock     (unlock),
        .unlock_wid (unlock_wid)
    );

    assign cmt_if.ready = cmt_ready;
    assign cmt_valid = cmt_if.valid;
    assign cmt_wid = cmt_if.wid;
    assign cmt_tmask = cmt_if.tmask;
    assign cmt_pc = cmt_if.pc;
    assign cmt_rd = cmt_if.rd;
    assign cmt_wb = cmt_if.wb;
    assign cmt_sop = cmt_if.sop;
    assign cmt_eop = cmt_if.eop;
    assign cmt_data = cmt_if.data;

endmodule

// File: test/csr_core_props.sv
// --------------------------------------------------------------------------
// Concurrent assertions for the CSR core: reset behavior, commit payload
// stability under back-pressure, and unlock tied to accepted requests
// --------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_core_props #(
    parameter int num_lanes = 4,
    parameter int num_warps = 4
) (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic req_ready,
    input logic req_eop,
    input logic unlock,
    input logic cmt_valid,
    input logic cmt_ready,
    input logic [csr_pkg::csr_wid_bits(num_warps)-1:0] cmt_wid,
    input logic [num_lanes-1:0] cmt_tmask,
    input logic [31:0] cmt_pc,
    input logic [4:0] cmt_rd,
    input logic cmt_wb,
    input logic cmt_sop,
    input logic cmt_eop,
    input logic [num_lanes-1:0][31:0] cmt_data
);

    // Reset empties the buffer by the following edge
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !cmt_valid)
        else $error("commit valid high after a reset cycle");

    reset_blocks_unlock: assert property (@(posedge clk) !rst_n |-> !unlock)
        else $error("unlock high during reset");

    commit_payload_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (cmt_valid && !cmt_ready) |=> (cmt_valid && $stable(cmt_wid) && $stable(cmt_tmask)
            && $stable(cmt_pc) && $stable(cmt_rd) && $stable(cmt_wb) && $stable(cmt_sop)
            && $stable(cmt_eop) && $stable(cmt_data)))
        else $error("commit record changed or dropped while stalled");

    unlock_needs_accept: assert property (@(posedge clk) disable iff (!rst_n)
        unlock |-> (req_valid && req_ready && req_eop))
        else $error("unlock without an accepted end-of-packet request");

endmodule

// File: test/csr_core_tb.sv
// --------------------------------------------------------------------------
// Testbench for the CSR core: clock, reset, request stimulus, reference
// model, commit compare process and watchdog
// --------------------------------------------------------------------------

`timescale 1ns/1ns

module csr_core_tb;

    localparam int num_lanes = 4;
    localparam int num_warps = 4;
    localparam int core_id = 0;
    localparam int wid_bits = csr_pkg::csr_wid_bits(num_warps);
    // ids 8, scratch 20, zero and read-only 9, random 40, idle 2, counters 3
    localparam int planned_reqs = 82;

    typedef struct packed {
        logic [wid_bits-1:0] wid;
        logic [num_lanes-1:0] tmask;
        logic [31:0] pc;
        logic [4:0] rd;
        logic wb;
        logic sop;
        logic eop;
    } ctrl_t;

    typedef struct packed {
        ctrl_t ctrl;
        logic [num_lanes-1:0][31:0] data;
    } rec_t;

    logic clk = 1'b0;
    logic rst_n;
    logic req_valid;
    logic req_ready;
    logic [wid_bits-1:0] req_wid;
    logic [num_lanes-1:0] req_tmask;
    logic [31:0] req_pc;
    logic [4:0] req_rd;
    logic req_wb;
    logic req_sop;
    logic req_eop;
    csr_pkg::csr_op_e req_op;
    csr_pkg::csr_addr_t req_addr;
    logic [csr_pkg::csr_zimm_width-1:0] req_zimm;
    logic req_use_imm;
    logic [num_lanes-1:0][31:0] req_rs1;
    logic [num_warps-1:0] warp_idle;
    logic retire;
    logic unlock;
    logic [wid_bits-1:0] unlock_wid;
    logic cmt_valid;
    logic cmt_ready;
    logic [wid_bits-1:0] cmt_wid;
    logic [num_lanes-1:0] cmt_tmask;
    logic [31:0] cmt_pc;
    logic [4:0] cmt_rd;
    logic cmt_wb;
    logic cmt_sop;
    logic cmt_eop;
    logic [num_lanes-1:0][31:0] cmt_data;

    rec_t exp_q[$];
    string name_q[$];
    string req_name;
    logic [31:0] next_pc;
    bit random_ready;
    int data_errors;
    int ctrl_errors;
    int other_errors;

    // Reference copy of the architectural CSRs
    logic [31:0] model_scratch [num_warps];
    logic [63:0] model_cycles;
    logic [31:0] model_retired;

    csr_core #(
        .num_lanes (num_lanes),
        .num_warps (num_warps),
        .core_id   (core_id)
    ) dut_i (.*);

    bind csr_core csr_core_props #(
        .num_lanes (num_lanes),
        .num_warps (num_warps)
    ) props_i (.*);

    always #5 clk = ~clk;

    function automatic logic [num_lanes-1:0][31:0] ref_csr(input logic [wid_bits-1:0] wid,
                                                          input csr_pkg::csr_op_e op,
                                                          input csr_pkg::csr_addr_t addr,
                                                          input logic [31:0] src);
        logic [num_lanes-1:0][31:0] lanes;
        logic [31:0] old;
        case (addr)
            csr_pkg::csr_mscratch: old = model_scratch[wid];
            csr_pkg::csr_mcycle: old = model_cycles[31:0];
            csr_pkg::csr_minstret: old = model_retired;
            csr_pkg::csr_warp_id: old = 32'(wid);
            default: old = 32'd0;
        endcase
        for (int i = 0; i < num_lanes; i++) begin
            if (addr == csr_pkg::csr_thread_id) begin
                lanes[i] = 32'(i);
            end else if (addr == csr_pkg::csr_mhartid) begin
                lanes[i] = 32'(core_id * num_warps * num_lanes + int'(wid) * num_lanes + i);
            end else begin
                lanes[i] = old;
            end
        end
        // Set and clear with a zero source leave the register alone
        if (addr == csr_pkg::csr_mscratch) begin
            if (op == csr_pkg::op_csrrw) begin
                model_scratch[wid] = src;
            end else if (op == csr_pkg::op_csrrs && src != 0) begin
                model_scratch[wid] = old | src;
            end else if (op == csr_pkg::op_csrrc && src != 0) begin
                model_scratch[wid] = old & ~src;
            end
        end
        return lanes;
    endfunction

    task automatic check_data(input string name, input logic [num_lanes-1:0][31:0] exp,
                              input logic [num_lanes-1:0][31:0] act);
        for (int i = 0; i < num_lanes; i++) begin
            if (act[i] !== exp[i]) begin
                data_errors++;
                $display("Error %s: lane %0d data expected %h actual %h",
                         name, i, exp[i], act[i]);
            end
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
        if (act !== exp) begin
            ctrl_errors++;
            $display("Error %s: control expected %h actual %h", name, exp, act);
        end
    endtask

    // Watches acceptances, updates the model and checks the scheduler unlock
    always @(posedge clk) begin : monitor
        rec_t rec;
        logic accept;
        logic [31:0] src;
        accept = rst_n && req_valid && (req_ready === 1'b1);
        if (accept) begin
            src = req_use_imm ? 32'(req_zimm) : req_rs1[0];
            if (!warp_idle[req_wid]) begin
                other_errors++;
                $display("A request was accepted while its warp was still busy");
            end
            rec.ctrl = ctrl_t'{req_wid, req_tmask, req_pc, req_rd, req_wb, req_sop, req_eop};
            rec.data = ref_csr(req_wid, req_op, req_addr, src);
            exp_q.push_back(rec);
            name_q.push_back(req_name);
        end
        if (rst_n && (unlock !== (accept && req_eop))) begin
            other_errors++;
            $display("Unlock pulse did not match an accepted end-of-packet request");
        end else if (rst_n && unlock && (unlock_wid !== req_wid)) begin
            ctrl_errors++;
            $display("Error %s: unlock wid expected %0d actual %0d",
                     req_name, req_wid, unlock_wid);
        end
        model_cycles = rst_n ? model_cycles + 64'd1 : 64'd0;
        if (!rst_n) begin
            model_retired = 32'd0;
        end else if (retire) begin
            model_retired = model_retired + 32'd1;
        end
    end

    always @(posedge clk) begin : compare
        rec_t exp_rec;
        string name;
        if (rst_n && (cmt_valid === 1'b1) && cmt_ready) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("A commit record arrived with no request outstanding");
            end else begin
                exp_rec = exp_q.pop_front();
                name = name_q.pop_front();
                check_ctrl(name, exp_rec.ctrl,
                           ctrl_t'{cmt_wid, cmt_tmask, cmt_pc, cmt_rd, cmt_wb, cmt_sop,
                                   cmt_eop});
                check_data(name, exp_rec.data, cmt_data);
            end
        end
    end

    task automatic send_req(input string name, input int wid, input csr_pkg::csr_op_e op,
                            input csr_pkg::csr_addr_t addr, input bit use_imm,
                            input logic [31:0] src, input bit eop);
        req_name = name;
        req_valid = 1'b1;
        req_wid = wid[wid_bits-1:0];
        req_tmask = $urandom % 15 + 1;
        req_pc = next_pc;
        next_pc = next_pc + 32'd4;
        req_rd = $urandom;
        req_wb = 1'b1;
        req_sop = $urandom % 2;
        req_eop = eop;
        req_op = op;
        req_addr = addr;
        req_use_imm = use_imm;
        req_zimm = use_imm ? src[4:0] : $urandom;
        for (int i = 0; i < num_lanes; i++) begin
            req_rs1[i] = $urandom;
        end
        if (!use_imm) begin
            req_rs1[0] = src;
        end
        do @(posedge clk); while (req_ready !== 1'b1);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drive_background();
        forever begin
            @(posedge clk);
            #1;
            retire = rst_n && ($urandom % 4 == 0);
            cmt_ready = random_ready ? 1'($urandom % 2) : 1'b1;
        end
    endtask

    task automatic read_ids();
        for (int w = 0; w < num_warps; w++) begin
            send_req("thread_id", w, csr_pkg::op_csrrs, csr_pkg::csr_thread_id, 1, 0, 0);
            send_req("hart_id", w, csr_pkg::op_csrrs, csr_pkg::csr_mhartid, 1, 0, 1);
        end
    endtask

    task automatic exercise_scratch();
        for (int w = 0; w < num_warps; w++) begin
            send_req("scratch_rw", w, csr_pkg::op_csrrw, csr_pkg::csr_mscratch, 0, $urandom, 0);
            send_req("scratch_set", w, csr_pkg::op_csrrs, csr_pkg::csr_mscratch, 1, w + 1, 0);
            send_req("scratch_clr", w, csr_pkg::op_csrrc, csr_pkg::csr_mscratch, 0, $urandom, 0);
            send_req("scratch_read", w, csr_pkg::op_csrrs, csr_pkg::csr_mscratch, 1, 0, 1);
        end
        for (int w = 0; w < num_warps; w++) begin
            send_req("scratch_final", w, csr_pkg::op_csrrs, csr_pkg::csr_mscratch, 1, 0, 1);
        end
    endtask

    task automatic zero_and_readonly();
        send_req("zero_set", 0, csr_pkg::op_csrrs, csr_pkg::csr_mscratch, 0, 0, 0);
        send_req("zero_clr", 1, csr_pkg::op_csrrc, csr_pkg::csr_mscratch, 1, 0, 0);
        send_req("zero_read", 0, csr_pkg::op_csrrs, csr_pkg::csr_mscratch, 1, 0, 0);
        send_req("zero_read", 1, csr_pkg::op_csrrs, csr_pkg::csr_mscratch, 1, 0, 1);
        send_req("ro_mcycle", 2, csr_pkg::op_csrrw, csr_pkg::csr_mcycle, 0, '1, 0);
        send_req("ro_minstret", 3, csr_pkg::op_csrrw, csr_pkg::csr_minstret, 0, '1, 0);
        send_req("unknown_wr", 0, csr_pkg::op_csrrw, 12'h7C0, 0, 32'h1234_5678, 0);
        send_req("unknown_rd", 0, csr_pkg::op_csrrs, 12'h7C0, 1, 0, 0);
        send_req("warp_id", 2, csr_pkg::op_csrrs, csr_pkg::csr_warp_id, 1, 0, 1);
    endtask

    task automatic random_traffic();
        csr_pkg::csr_addr_t addrs [7];
        logic [31:0] src;
        addrs = '{csr_pkg::csr_mscratch, csr_pkg::csr_mcycle, csr_pkg::csr_minstret,
                  csr_pkg::csr_warp_id, csr_pkg::csr_thread_id, csr_pkg::csr_mhartid, 12'h7C0};
        random_ready = 1'b1;
        for (int n = 0; n < 40; n++) begin
            src = ($urandom % 4 == 0) ? 32'd0 : $urandom;
            send_req("random", $urandom % num_warps, csr_pkg::csr_op_e'(1 + $urandom % 3),
                     addrs[$urandom % 7], $urandom % 2, src, $urandom % 2);
        end
        random_ready = 1'b0;
    endtask

    task automatic idle_gating();
        warp_idle = 4'b1011;
        fork
            send_req("idle_wait", 2, csr_pkg::op_csrrs, csr_pkg::csr_warp_id, 1, 0, 1);
            begin
                repeat (5) begin
                    @(posedge clk);
                    if (req_ready !== 1'b0) begin
                        other_errors++;
                        $display("Request for a busy warp was ready before warp_idle rose");
                    end
                end
                #1;
                warp_idle = '1;
            end
        join
        send_req("idle_after", 3, csr_pkg::op_csrrs, csr_pkg::csr_warp_id, 1, 0, 1);
    endtask

    task automatic counter_reads();
        send_req("mcycle_first", 0, csr_pkg::op_csrrs, csr_pkg::csr_mcycle, 1, 0, 0);
        repeat (7) @(posedge clk);
        #1;
        send_req("mcycle_second", 0, csr_pkg::op_csrrs, csr_pkg::csr_mcycle, 1, 0, 0);
        send_req("minstret", 0, csr_pkg::op_csrrs, csr_pkg::csr_minstret, 1, 0, 1);
    endtask

    initial begin : watchdog
        repeat (200 * planned_reqs) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", 200 * planned_reqs);
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        void'($urandom(32'h8a7aef70));
        rst_n = 1'b0;
        // An end-of-packet request held through reset must not unlock the scheduler
        req_valid = 1'b1;
        req_wid = '0;
        req_tmask = '0;
        req_pc = '0;
        req_rd = '0;
        req_wb = 1'b0;
        req_sop = 1'b0;
        req_eop = 1'b1;
        req_op = csr_pkg::op_csrrs;
        req_addr = '0;
        req_zimm = '0;
        req_use_imm = 1'b0;
        req_rs1 = '0;
        warp_idle = '1;
        retire = 1'b0;
        cmt_ready = 1'b1;
        next_pc = 32'h0000_1000;
        for (int w = 0; w < num_warps; w++) begin
            model_scratch[w] = 32'd0;
        end
        model_cycles = 64'd0;
        model_retired = 32'd0;
        fork
            drive_background();
        join_none
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        req_valid = 1'b0;
        req_eop = 1'b0;
        @(posedge clk);
        #1;
        read_ids();
        exercise_scratch();
        zero_and_readonly();
        random_traffic();
        idle_gating();
        counter_reads();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        $display("Errors: data %0d, control %0d, other %0d", data_errors, ctrl_errors,
                 other_errors);
        if (data_errors + ctrl_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: csr_core.f
logic/csr_pkg.sv
logic/csr_req_if.sv
logic/csr_commit_if.sv
logic/csr_data.sv
logic/csr_rsp_buffer.sv
logic/csr_unit.sv
logic/csr_core.sv
test/csr_core_props.sv
test/csr_core_tb.sv
